// File: logic/icache_defines.svh
/* geometry of the instruction cache: 64-bit byte address, one 32-bit word per line
   index comes from address bits 8..3 and the tag from bits 63..9 */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch and memory address
`define ICACHE_ADDR_W   64

// one instruction word per line
`define ICACHE_DATA_W   32

// address split, tag + index + offset must equal ICACHE_ADDR_W
`define ICACHE_TAG_W    55
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

`define ICACHE_SETS     64

// saturating age per way
`define ICACHE_AGE_W    3

`endif

// File: logic/icache_pkg.sv
/* shared cache types; widths come from the defines header
   way_sel_t is one bit per way, way0 in bit 0 */
`include "icache_defines.svh"

package icache_pkg;

    // tag RAM entry, valid bits live in the replacement block
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // byte address split as the cache sees it
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // hit, victim and write-enable vectors
    typedef struct packed {
        logic way1;
        logic way0;
    } way_sel_t;

    // fetch FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

// File: logic/icache_way_ram.sv
/* single-port RAM with registered read every cycle, old data on a same-cycle write
   no reset, so unwritten entries read as X until the valid bits say otherwise */
`timescale 1ns/100ps

module icache_way_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] i_index,
    input  logic                     i_we,
    input  payload_t                 i_wdata,
    output payload_t                 o_rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index] <= i_wdata;
        end
        // read-before-write
        o_rdata <= mem[i_index];
    end

endmodule

// File: logic/icache_repl.sv
/* valid bits and 3-bit saturating ages for both ways of every set
   victim: first invalid way (way0 first), else the older way, way0 on a tie */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_repl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_INDEX_W-1:0] i_index,
    input  logic                       i_age_all,
    input  logic                       i_touch,
    input  icache_pkg::way_sel_t       i_touch_way,
    input  logic                       i_fill,
    output icache_pkg::way_sel_t       o_valid,
    output icache_pkg::way_sel_t       o_victim
);
    import icache_pkg::*;

    localparam logic [`ICACHE_AGE_W-1:0] AGE_MAX = '1;

    way_sel_t                  valid_q [`ICACHE_SETS];
    logic [`ICACHE_AGE_W-1:0]  age_q   [`ICACHE_SETS][2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s]  <= '0;
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else begin
            if (i_age_all) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    for (int w = 0; w < 2; w++) begin
                        if (age_q[s][w] != AGE_MAX) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
            end
            // later assignment, so the touch beats aging
            if (i_touch) begin
                if (i_touch_way.way0) begin
                    age_q[i_index][0] <= '0;
                end
                if (i_touch_way.way1) begin
                    age_q[i_index][1] <= '0;
                end
                if (i_fill) begin
                    valid_q[i_index] <= valid_q[i_index] | i_touch_way;
                end
            end
        end
    end

    assign o_valid = valid_q[i_index];

    always_comb begin
        o_victim = '0;
        if (!o_valid.way0) begin
            o_victim.way0 = 1'b1;
        end else if (!o_valid.way1) begin
            o_victim.way1 = 1'b1;
        end else if (age_q[i_index][1] > age_q[i_index][0]) begin
            o_victim.way1 = 1'b1;
        end else begin
            o_victim.way0 = 1'b1;
        end
    end

    a_touch_onehot: assert property (@(posedge clk) disable iff (!rst)
        i_touch |-> $onehot(i_touch_way));

    // a fill comes with a touch of the victim way
    a_fill_victim: assert property (@(posedge clk) disable iff (!rst)
        i_fill |-> i_touch && (i_touch_way == o_victim));

endmodule

// File: logic/icache_ctrl.sv
/* one fetch at a time, i_fetch_req is only taken in IDLE; hit answers two cycles after it
   miss holds o_mem_req until i_mem_ack and answers the cycle after the acknowledge */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // fetch side
    input  logic                       i_fetch_req,
    input  icache_pkg::fetch_addr_t    i_fetch_addr,
    output logic                       o_fetch_valid,
    output logic [`ICACHE_DATA_W-1:0]  o_fetch_data,
    // memory side
    output logic                       o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_addr,
    input  logic                       i_mem_ack,
    input  logic [`ICACHE_DATA_W-1:0]  i_mem_data,
    // way RAMs
    output logic [`ICACHE_INDEX_W-1:0] o_index,
    output icache_pkg::way_sel_t       o_tag_we,
    output icache_pkg::way_sel_t       o_data_we,
    output icache_pkg::tag_entry_t     o_wtag,
    output logic [`ICACHE_DATA_W-1:0]  o_wdata,
    input  icache_pkg::tag_entry_t     i_rtag0,
    input  icache_pkg::tag_entry_t     i_rtag1,
    input  logic [`ICACHE_DATA_W-1:0]  i_rdata0,
    input  logic [`ICACHE_DATA_W-1:0]  i_rdata1,
    // replacement block
    output logic                       o_age_all,
    output logic                       o_touch,
    output icache_pkg::way_sel_t       o_touch_way,
    output logic                       o_fill,
    input  icache_pkg::way_sel_t       i_valid,
    input  icache_pkg::way_sel_t       i_victim
);
    import icache_pkg::*;

    ctrl_state_t               state_q;
    ctrl_state_t               state_d;
    fetch_addr_t               addr_q;
    logic [`ICACHE_DATA_W-1:0] resp_data_q;
    way_sel_t                  hit;
    logic                      accept;
    logic                      lookup_hit;
    logic                      fill;

    assign accept = (state_q == IDLE) && i_fetch_req;

    // tags and valid bits both refer to addr_q.index during LOOKUP
    always_comb begin
        hit.way0 = i_valid.way0 && (i_rtag0.tag == addr_q.tag);
        hit.way1 = i_valid.way1 && (i_rtag1.tag == addr_q.tag);
    end

    assign lookup_hit = (state_q == LOOKUP) && (hit != '0);
    assign fill       = (state_q == REFILL) && i_mem_ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_fetch_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit != '0) begin
                    state_d = RESPOND;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (i_mem_ack) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address captured once, held through the miss
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            resp_data_q <= hit.way0 ? i_rdata0 : i_rdata1;
        end else if (fill) begin
            resp_data_q <= i_mem_data;
        end
    end

    assign o_fetch_valid = (state_q == RESPOND);
    assign o_fetch_data  = resp_data_q;

    assign o_mem_req  = (state_q == REFILL);
    assign o_mem_addr = addr_q;

    // incoming address while idle so the RAM read lands in LOOKUP
    assign o_index = (state_q == IDLE) ? i_fetch_addr.index : addr_q.index;

    assign o_tag_we   = fill ? i_victim : '0;
    assign o_data_we  = fill ? i_victim : '0;
    assign o_wtag.tag = addr_q.tag;
    assign o_wdata    = i_mem_data;

    assign o_age_all   = accept;
    assign o_touch     = lookup_hit || fill;
    assign o_touch_way = fill ? i_victim : hit;
    assign o_fill      = fill;

    // a tag is only ever filled on a miss, so it sits in one way at most
    a_hit_not_two_hot: assert property (@(posedge clk) disable iff (!rst)
        (state_q == LOOKUP) |-> !(hit.way0 && hit.way1));

    a_req_only_idle: assert property (@(posedge clk) disable iff (!rst)
        i_fetch_req |-> (state_q == IDLE));

endmodule

// File: logic/icache_top.sv
/* two-way instruction cache, one 32-bit word per line, read-only
   memory side is a request level answered by a single-cycle acknowledge */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_fetch_req,
    input  icache_pkg::fetch_addr_t   i_fetch_addr,
    output logic                      o_fetch_valid,
    output logic [`ICACHE_DATA_W-1:0] o_fetch_data,
    output logic                      o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0] o_mem_addr,
    input  logic                      i_mem_ack,
    input  logic [`ICACHE_DATA_W-1:0] i_mem_data
);
    import icache_pkg::*;

    logic [`ICACHE_INDEX_W-1:0] index;
    way_sel_t                   tag_we;
    way_sel_t                   data_we;
    tag_entry_t                 wtag;
    logic [`ICACHE_DATA_W-1:0]  wdata;
    tag_entry_t                 rtag0;
    tag_entry_t                 rtag1;
    logic [`ICACHE_DATA_W-1:0]  rdata0;
    logic [`ICACHE_DATA_W-1:0]  rdata1;
    logic                       age_all;
    logic                       touch;
    way_sel_t                   touch_way;
    logic                       fill;
    way_sel_t                   valid;
    way_sel_t                   victim;

    icache_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_ack     (i_mem_ack),
        .i_mem_data    (i_mem_data),
        .o_index       (index),
        .o_tag_we      (tag_we),
        .o_data_we     (data_we),
        .o_wtag        (wtag),
        .o_wdata       (wdata),
        .i_rtag0       (rtag0),
        .i_rtag1       (rtag1),
        .i_rdata0      (rdata0),
        .i_rdata1      (rdata1),
        .o_age_all     (age_all),
        .o_touch       (touch),
        .o_touch_way   (touch_way),
        .o_fill        (fill),
        .i_valid       (valid),
        .i_victim      (victim)
    );

    icache_repl repl_i (
        .clk         (clk),
        .rst         (rst),
        .i_index     (index),
        .i_age_all   (age_all),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_fill      (fill),
        .o_valid     (valid),
        .o_victim    (victim)
    );

    // tag arrays
    icache_way_ram #(.payload_t(tag_entry_t), .DEPTH(`ICACHE_SETS)) tag0_ram_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (tag_we.way0),
        .i_wdata (wtag),
        .o_rdata (rtag0)
    );

    icache_way_ram #(.payload_t(tag_entry_t), .DEPTH(`ICACHE_SETS)) tag1_ram_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (tag_we.way1),
        .i_wdata (wtag),
        .o_rdata (rtag1)
    );

    // data arrays
    icache_way_ram #(
        .payload_t (logic [`ICACHE_DATA_W-1:0]),
        .DEPTH     (`ICACHE_SETS)
    ) data0_ram_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (data_we.way0),
        .i_wdata (wdata),
        .o_rdata (rdata0)
    );

    icache_way_ram #(
        .payload_t (logic [`ICACHE_DATA_W-1:0]),
        .DEPTH     (`ICACHE_SETS)
    ) data1_ram_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (data_we.way1),
        .i_wdata (wdata),
        .o_rdata (rdata1)
    );

endmodule

// File: verif/icache_checker.sv
/* reference model of the two-way cache, samples DUT ports on the falling clock edge
   assumes one fetch at a time and memory words equal to the low address bits xor MEM_KEY */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_checker #(
    parameter logic [31:0] MEM_KEY = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_fetch_req,
    input  logic [`ICACHE_ADDR_W-1:0] i_fetch_addr,
    input  logic                      i_fetch_valid,
    input  logic [`ICACHE_DATA_W-1:0] i_fetch_data,
    input  logic                      i_mem_req,
    input  logic [`ICACHE_ADDR_W-1:0] i_mem_addr,
    input  logic                      i_mem_ack,
    output int                        o_errors,
    output int                        o_checks
);
    localparam int AGE_MAX = (1 << `ICACHE_AGE_W) - 1;

    logic                      valid_m [`ICACHE_SETS][2];
    logic [`ICACHE_TAG_W-1:0]  tag_m   [`ICACHE_SETS][2];
    logic [`ICACHE_DATA_W-1:0] data_m  [`ICACHE_SETS][2];
    int                        age_m   [`ICACHE_SETS][2];

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        o_checks++;
        if (got !== exp) begin
            o_errors++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                valid_m[s][w] = 1'b0;
                age_m[s][w]   = 0;
            end
        end
    endtask

    task automatic run_fetch(input logic [`ICACHE_ADDR_W-1:0] addr);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_DATA_W-1:0]  exp_data;
        int                         way;
        logic                       hit;
        idx = addr[8:3];
        tag = addr[63:9];
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[idx][w] && tag_m[idx][w] == tag) way = w;
        end
        hit = (way >= 0);
        // acceptance ages every entry
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (age_m[s][w] < AGE_MAX) age_m[s][w]++;
            end
        end
        if (hit) begin
            exp_data        = data_m[idx][way];
            age_m[idx][way] = 0;
        end else begin
            // invalid way first, then the older one, way 0 on a tie
            if (!valid_m[idx][0]) way = 0;
            else if (!valid_m[idx][1]) way = 1;
            else way = (age_m[idx][1] > age_m[idx][0]) ? 1 : 0;
            exp_data          = addr[31:0] ^ MEM_KEY;
            valid_m[idx][way] = 1'b1;
            tag_m[idx][way]   = tag;
            data_m[idx][way]  = exp_data;
            age_m[idx][way]   = 0;
        end
        // lookup cycle
        @(negedge clk);
        expect_eq("o_fetch_valid", i_fetch_valid, 1'b0);
        expect_eq("o_mem_req", i_mem_req, 1'b0);
        @(negedge clk);
        if (!hit) begin
            // miss, request held through the acknowledge
            expect_eq("o_mem_req", i_mem_req, 1'b1);
            expect_eq("o_mem_addr", i_mem_addr, addr);
            expect_eq("o_fetch_valid", i_fetch_valid, 1'b0);
            while (i_mem_req === 1'b1 && i_mem_ack !== 1'b1) begin
                @(negedge clk);
                expect_eq("o_mem_req", i_mem_req, 1'b1);
                expect_eq("o_fetch_valid", i_fetch_valid, 1'b0);
            end
            @(negedge clk);
        end
        expect_eq("o_fetch_valid", i_fetch_valid, 1'b1);
        expect_eq("o_fetch_data", i_fetch_data, exp_data);
        expect_eq("o_mem_req", i_mem_req, 1'b0);
    endtask

    initial begin
        o_errors = 0;
        o_checks = 0;
        clear_model();
        forever begin
            @(negedge clk);
            if (rst === 1'b1 && i_fetch_req === 1'b1) begin
                run_fetch(i_fetch_addr);
            end else begin
                // idle or in reset, nothing may come out
                if (rst !== 1'b1) clear_model();
                expect_eq("o_fetch_valid", i_fetch_valid, 1'b0);
                expect_eq("o_mem_req", i_mem_req, 1'b0);
            end
        end
    end

endmodule

// File: verif/icache_tb.sv
/* random fetches from a small address pool, three sets with four tags each
   memory word is the low address bits xor MEM_KEY, answered 1 to 6 cycles after o_mem_req */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int          CLK_PERIOD       = 4;
    localparam int unsigned RAND_SEED        = 32'hfc05_c88b;
    localparam logic [31:0] MEM_KEY          = 32'h5a3c_96e1;
    localparam int          DIRECTED_FETCHES = 19;
    localparam int          RANDOM_FETCHES   = 300;
    // request, lookup, memory wait, response and an idle gap
    localparam int          WORST_CYCLES     = 14;
    localparam int          TIMEOUT_NS       =
        (DIRECTED_FETCHES + RANDOM_FETCHES) * WORST_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;

    logic                       clk      = 1'b0;
    logic                       rst;
    logic                       fetch_req;
    fetch_addr_t                fetch_addr;
    logic                       fetch_valid;
    logic [`ICACHE_DATA_W-1:0]  fetch_data;
    logic                       mem_req;
    logic [`ICACHE_ADDR_W-1:0]  mem_addr;
    logic                       mem_ack  = 1'b0;
    logic [`ICACHE_DATA_W-1:0]  mem_data = '0;
    logic                       mem_busy = 1'b0;
    int unsigned                mem_wait = 0;
    int                         chk_errors;
    int                         chk_checks;
    int                         errors_before;
    logic [`ICACHE_INDEX_W-1:0] set_pool [3];
    logic [`ICACHE_TAG_W-1:0]   tag_pool [3][4];

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .o_fetch_valid (fetch_valid),
        .o_fetch_data  (fetch_data),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .i_mem_ack     (mem_ack),
        .i_mem_data    (mem_data)
    );

    icache_checker #(.MEM_KEY(MEM_KEY)) checker_i (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .i_fetch_valid (fetch_valid),
        .i_fetch_data  (fetch_data),
        .i_mem_req     (mem_req),
        .i_mem_addr    (mem_addr),
        .i_mem_ack     (mem_ack),
        .o_errors      (chk_errors),
        .o_checks      (chk_checks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory model, one acknowledge per request
    always @(posedge clk) begin
        if (!rst) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_ack  <= 1'b1;
                    mem_data <= mem_addr[31:0] ^ MEM_KEY;
                    mem_busy <= 1'b0;
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end else if (mem_req && !mem_ack) begin
                mem_busy <= 1'b1;
                mem_wait <= $urandom_range(5, 0);
            end
        end
    end

    function automatic fetch_addr_t make_addr(input int s, input int t, input logic [2:0] off);
        fetch_addr_t a;
        a.tag    = tag_pool[s][t];
        a.index  = set_pool[s];
        a.offset = off;
        return a;
    endfunction

    // starts on a rising edge, returns on the edge that ends the response cycle
    task automatic fetch_once(input fetch_addr_t addr);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        @(posedge clk);
        fetch_req  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!fetch_valid);
    endtask

    task automatic reset_dut();
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = chk_errors - errors_before;
        $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "FAILED", errs);
        errors_before = chk_errors;
    endtask

    initial begin
        logic [63:0] rand_bits;
        rst           = 1'b0;
        fetch_req     = 1'b0;
        fetch_addr    = '0;
        errors_before = 0;
        void'($urandom(RAND_SEED));
        set_pool[0] = 6'd5;
        set_pool[1] = 6'd17;
        set_pool[2] = 6'd42;
        for (int s = 0; s < 3; s++) begin
            for (int t = 0; t < 4; t++) begin
                rand_bits      = {$urandom(), $urandom()};
                tag_pool[s][t] = rand_bits[`ICACHE_TAG_W-1:0];
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        for (int s = 0; s < 3; s++) fetch_once(make_addr(s, 0, 3'd0));
        report_test(1, "cold miss");
        for (int s = 0; s < 3; s++) fetch_once(make_addr(s, 0, 3'd0));
        report_test(2, "hit");
        fetch_once(make_addr(0, 1, 3'd0));
        for (int i = 0; i < 6; i++) fetch_once(make_addr(0, i % 2, 3'd0));
        report_test(3, "two tags");
        // tag 0 is the older way here, so tag 2 takes its place
        fetch_once(make_addr(0, 2, 3'd0));
        fetch_once(make_addr(0, 1, 3'd0));
        fetch_once(make_addr(0, 0, 3'd0));
        report_test(4, "replacement");
        reset_dut();
        for (int s = 0; s < 3; s++) fetch_once(make_addr(s, 0, 3'd0));
        report_test(5, "reset");
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            fetch_once(make_addr($urandom_range(2, 0), $urandom_range(3, 0),
                                 3'($urandom_range(7, 0))));
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
        report_test(6, "random");

        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", chk_checks, chk_errors);
        if (chk_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not end within %0d ns, a fetch hung", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_way_ram.sv
logic/icache_repl.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv
